// ==== project.f ====
hw/fetch_pkg.sv
hw/beat_counter.sv
hw/icache_array.sv
hw/refill_buffer.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
verif/axi_mem_model.sv
verif/tb_fetch.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module tb_fetch -f project.f
	@out=$$(./obj_dir/Vtb_fetch); echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== verif/tb_fetch.sv ====
`timescale 1ns/100ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam int          RST_CYCLES = 16;
    localparam int          NUM_TESTS  = 24;
    localparam logic [31:0] SEED       = 32'h2a4cd212;

    logic       clk;
    logic       rst;
    logic       pc_valid;
    addr_t      pc;
    logic       pc_ready;
    logic       inst_valid;
    word_t      inst;
    logic       access_fault;
    logic       inst_ready;
    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    logic [3:0] arid;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       rvalid;
    logic       rready;
    word_t      rdata;
    resp_t      rresp;
    logic       rlast;
    logic [3:0] rid;
    int         ar_count;

    addr_t tbl_pc    [NUM_TESTS];
    word_t tbl_inst  [NUM_TESTS];
    logic  tbl_fault [NUM_TESTS];
    int    tbl_count [NUM_TESTS];
    int    n_entries;
    addr_t cur_pc;
    int    count_base;      // AR count before the current fetch.
    logic  hold_q;
    word_t inst_q;
    logic  fault_q;

    fetch_top u_dut (.*);

    axi_mem_model u_mem (.*);

    function automatic word_t rule_word(addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        $display("mismatch %s exp %h got %h", name, exp, got);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t exp, word_t got);
        if (got !== exp)
            report_mismatch(name, exp, got);
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t got);
        if (got !== exp)
            report_mismatch(name, exp, got);
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        if (got !== exp)
            report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_field(string name, logic [7:0] exp, logic [7:0] got);
        if (got !== exp)
            report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_count(string name, int exp, int got);
        if (got != exp)
            report_mismatch(name, exp, got);
    endtask

    task automatic add_entry(addr_t a, logic fault, int count);
        tbl_pc[n_entries]    = a;
        tbl_inst[n_entries]  = rule_word(a);
        tbl_fault[n_entries] = fault;
        tbl_count[n_entries] = count;
        n_entries++;
    endtask

    task automatic fill_table();
        add_entry(32'h0000_1000, 1'b0, 4);     // Cold miss, single beats.
        add_entry(32'h0000_1004, 1'b0, 0);
        add_entry(32'h0000_100C, 1'b0, 0);
        add_entry(32'hA000_0020, 1'b0, 1);     // Cold miss, one burst.
        add_entry(32'hA000_002C, 1'b0, 0);
        add_entry(32'hA000_0024, 1'b0, 0);
        add_entry(32'h3000_0040, 1'b1, 1);     // Fault window.
        add_entry(32'h3000_0040, 1'b1, 1);     // Never cached, misses again.
        add_entry(32'h3000_0048, 1'b1, 1);
        add_entry(32'h0000_2014, 1'b0, 4);     // Same index, two tags.
        add_entry(32'h0000_3014, 1'b0, 4);
        add_entry(32'h0000_2018, 1'b0, 4);
        add_entry(32'h0000_3010, 1'b0, 4);
        add_entry(32'h0000_301C, 1'b0, 0);
        add_entry(32'hBFFF_FFF0, 1'b0, 1);     // Top of the burst region.
        add_entry(32'hBFFF_FFFC, 1'b0, 0);
        add_entry(32'hA000_1020, 1'b0, 1);     // Burst lines evict each other.
        add_entry(32'hA000_0028, 1'b0, 1);
        add_entry(32'h0000_1008, 1'b0, 0);
        add_entry(32'h3000_00F0, 1'b1, 1);     // Old line in index 15 survives.
        add_entry(32'hBFFF_FFF4, 1'b0, 0);
        add_entry(32'h3000_0100, 1'b0, 4);     // Just past the fault window.
        add_entry(32'h0000_1004, 1'b0, 4);
        add_entry(32'h9FFF_FFF0, 1'b0, 4);     // Just below the burst region.
    endtask

    task automatic run_entry(int i);
        int stall;
        @(posedge clk);
        cur_pc     = tbl_pc[i];
        count_base = ar_count;
        pc_valid   <= 1'b1;
        pc         <= tbl_pc[i];
        @(posedge clk);
        while (!pc_ready)
            @(posedge clk);
        pc_valid <= 1'b0;
        @(posedge clk);
        while (!inst_valid)
            @(posedge clk);
        stall = $urandom_range(3);
        repeat (stall) @(posedge clk);
        inst_ready <= 1'b1;
        @(posedge clk);
        check_flag("inst_valid", 1'b1, inst_valid);
        if (!tbl_fault[i])
            check_word("inst", tbl_inst[i], inst);
        check_flag("access_fault", tbl_fault[i], access_fault);
        check_count("ar_count", tbl_count[i], ar_count - count_base);
        inst_ready <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RST_CYCLES + NUM_TESTS * 200) * CLK_PERIOD);
        $display("timeout: no response from fetch unit");
        $display("TEST FAIL");
        $fatal(1);
    end

    // Every AR handshake against the region rule of the current fetch.
    always @(posedge clk) begin
        logic  sdram;
        addr_t base;
        sdram = (cur_pc >= SDRAM_BASE) && (cur_pc <= SDRAM_END);
        base  = {cur_pc[31:4], 4'h0};
        if (!rst && arvalid && arready) begin
            check_field("arsize", 8'd2, 8'(arsize));
            check_field("arid", 8'(FETCH_ID), 8'(arid));
            if (sdram) begin
                check_field("arlen", 8'd3, arlen);
                check_field("arburst", 8'd1, 8'(arburst));
                check_addr("araddr", base, araddr);
            end else begin
                check_field("arlen", 8'd0, arlen);
                check_field("arburst", 8'd0, 8'(arburst));
                check_addr("araddr", base + 32'(4 * (ar_count - count_base)), araddr);
            end
        end
    end

    // pc_ready only when idle, rready only while data is awaited.
    always @(posedge clk) begin
        if (!rst && pc_ready) begin
            check_flag("inst_valid with pc_ready", 1'b0, inst_valid);
            check_flag("arvalid with pc_ready", 1'b0, arvalid);
            check_flag("rready with pc_ready", 1'b0, rready);
        end
        if (!rst && (arvalid || inst_valid))
            check_flag("rready outside data", 1'b0, rready);
    end

    // Response held while the pipeline stalls.
    always @(posedge clk) begin
        if (!rst && hold_q) begin
            check_flag("inst_valid held", 1'b1, inst_valid);
            check_word("inst held", inst_q, inst);
            check_flag("access_fault held", fault_q, access_fault);
        end
        hold_q  <= inst_valid && !inst_ready;
        inst_q  <= inst;
        fault_q <= access_fault;
    end

    initial begin
        void'($urandom(SEED));
        rst        <= 1'b1;
        pc_valid   <= 1'b0;
        pc         <= '0;
        inst_ready <= 1'b0;
        cur_pc     = '0;
        count_base = 0;
        n_entries  = 0;
        fill_table();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_entries; i++)
            run_entry(i);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       arvalid,
    output logic       arready,
    input  addr_t      araddr,
    input  logic [3:0] arid,
    input  logic [7:0] arlen,
    input  logic [1:0] arburst,
    output logic       rvalid,
    input  logic       rready,
    output word_t      rdata,
    output resp_t      rresp,
    output logic       rlast,
    output logic [3:0] rid,
    output int         ar_count
);

    localparam resp_t SLVERR = 2'b10;

    logic       busy;
    addr_t      addr_q;
    logic [7:0] left_q;     // Beats after the current one.
    logic [1:0] burst_q;
    int         stall_q;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= RESP_OKAY;
            rlast    <= 1'b0;
            rid      <= '0;
            busy     <= 1'b0;
            stall_q  <= 0;
            ar_count <= 0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready  <= 1'b0;
                busy     <= 1'b1;
                addr_q   <= araddr;
                left_q   <= (arlen < 8'(LINE_WORDS)) ? arlen : 8'(LINE_WORDS - 1);
                burst_q  <= arburst;
                rid      <= arid;
                ar_count <= ar_count + 1;
                stall_q  <= $urandom_range(3);
            end else if (arvalid) begin
                if (stall_q == 0)
                    arready <= 1'b1;
                else
                    stall_q <= stall_q - 1;
            end
        end else if (rvalid) begin
            if (rready) begin
                rvalid  <= 1'b0;
                busy    <= !rlast;
                left_q  <= left_q - 8'd1;
                addr_q  <= (burst_q == 2'b01) ? addr_q + 32'd4 : addr_q;   // INCR only.
                stall_q <= $urandom_range(3);
            end
        end else if (stall_q == 0) begin
            rvalid <= 1'b1;
            rdata  <= addr_q ^ 32'h5A5A_0000;
            rresp  <= (addr_q >= 32'h3000_0000 && addr_q <= 32'h3000_00FF) ? SLVERR : RESP_OKAY;
            rlast  <= (left_q == 8'd0);
        end else begin
            stall_q <= stall_q - 1;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pc_valid,
    input  addr_t      pc,
    output logic       pc_ready,
    output logic       inst_valid,
    output word_t      inst,
    output logic       access_fault,
    input  logic       inst_ready,
    output logic       arvalid,
    input  logic       arready,
    output addr_t      araddr,
    output logic [3:0] arid,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    input  logic       rvalid,
    output logic       rready,
    input  word_t      rdata,
    input  resp_t      rresp,
    input  logic       rlast,
    input  logic [3:0] rid
);

    logic   hit;
    word_t  rd_word;
    logic   lookup_en;
    index_t lookup_idx;
    tag_t   lookup_tag;
    logic   line_we;
    index_t line_idx;
    tag_t   line_tag;
    line_t  line;
    logic   beat_clr;
    logic   beat_inc;
    logic   beat_take;
    beat_t  beat;
    logic   beat_last;
    logic   err;

    assign arid   = FETCH_ID;       // Single ID, so rid is not checked.
    assign arsize = AR_SIZE_WORD;

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .pc_valid     (pc_valid),
        .pc           (pc),
        .inst_ready   (inst_ready),
        .hit          (hit),
        .rd_word      (rd_word),
        .beat_last    (beat_last),
        .err          (err),
        .arready      (arready),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .pc_ready     (pc_ready),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .access_fault (access_fault),
        .lookup_en    (lookup_en),
        .lookup_idx   (lookup_idx),
        .lookup_tag   (lookup_tag),
        .line_we      (line_we),
        .line_idx     (line_idx),
        .line_tag     (line_tag),
        .beat_clr     (beat_clr),
        .beat_inc     (beat_inc),
        .beat_take    (beat_take),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arburst      (arburst),
        .rready       (rready)
    );

    beat_counter u_beat (
        .clk       (clk),
        .rst       (rst),
        .clr       (beat_clr),
        .inc       (beat_inc),
        .beat      (beat),
        .beat_last (beat_last)
    );

    icache_array u_cache (
        .clk        (clk),
        .rst        (rst),
        .lookup_en  (lookup_en),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .word_sel   (pc[3:2]),      // Valid while the request is accepted.
        .line_we    (line_we),
        .line_idx   (line_idx),
        .line_tag   (line_tag),
        .line       (line),
        .hit        (hit),
        .rd_word    (rd_word)
    );

    refill_buffer u_refill (
        .clk   (clk),
        .rst   (rst),
        .clr   (beat_clr),
        .take  (beat_take),
        .beat  (beat),
        .rdata (rdata),
        .rresp (rresp),
        .line  (line),
        .err   (err)
    );

endmodule

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/100ps

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pc_valid,
    input  addr_t      pc,
    input  logic       inst_ready,
    input  logic       hit,
    input  word_t      rd_word,
    input  logic       beat_last,
    input  logic       err,
    input  logic       arready,
    input  logic       rvalid,
    input  logic       rlast,
    output logic       pc_ready,
    output logic       inst_valid,
    output word_t      inst,
    output logic       access_fault,
    output logic       lookup_en,
    output index_t     lookup_idx,
    output tag_t       lookup_tag,
    output logic       line_we,
    output index_t     line_idx,
    output tag_t       line_tag,
    output logic       beat_clr,
    output logic       beat_inc,
    output logic       beat_take,
    output logic       arvalid,
    output addr_t      araddr,
    output logic [7:0] arlen,
    output logic [1:0] arburst,
    output logic       rready
);

    ctrl_state_t state;
    addr_t       pc_q;
    addr_t       araddr_q;
    logic        sdram_q;   // Burst region.
    logic        chk_q;     // Beat taken, decide next step.
    logic        fin_q;     // Last word of the line was taken.
    logic        fault_q;
    logic        ready_q;
    logic        finish;

    assign pc_ready   = (state == IDLE) && ready_q;
    assign lookup_en  = pc_valid && pc_ready;
    assign lookup_idx = pc[7:4];
    assign lookup_tag = pc[31:8];
    assign line_idx   = pc_q[7:4];
    assign line_tag   = pc_q[31:8];

    assign arvalid = (state == ADDR);
    assign araddr  = araddr_q;
    assign arlen   = sdram_q ? AR_LEN_LINE : AR_LEN_SINGLE;
    assign arburst = sdram_q ? BURST_INCR : BURST_FIXED;

    assign rready    = (state == DATA) && !chk_q;
    assign beat_take = rvalid && rready;
    assign beat_inc  = beat_take;
    assign beat_clr  = (state == LOOKUP) && !hit;

    // A burst always ends here, single reads only on error or the last word.
    assign finish  = (state == DATA) && chk_q && (err || fin_q || sdram_q);
    assign line_we = finish && fin_q && !err;

    assign inst_valid   = (state == RESP);
    assign inst         = fault_q ? '0 : rd_word;
    assign access_fault = fault_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            ready_q <= 1'b0;
            sdram_q <= 1'b0;
            chk_q   <= 1'b0;
            fin_q   <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            case (state)
                IDLE: begin
                    if (lookup_en)
                        state <= LOOKUP;
                end
                LOOKUP: begin
                    sdram_q <= (pc_q >= SDRAM_BASE) && (pc_q <= SDRAM_END);
                    fault_q <= 1'b0;
                    state   <= hit ? RESP : ADDR;
                end
                ADDR: begin
                    if (arready)
                        state <= DATA;
                end
                DATA: begin
                    if (beat_take) begin
                        chk_q <= !sdram_q || rlast;
                        fin_q <= beat_last;
                    end
                    if (chk_q) begin
                        chk_q <= 1'b0;
                        if (finish) begin
                            fault_q <= err || !fin_q;   // Short burst counts as a fault.
                            state   <= RESP;
                        end else begin
                            state <= ADDR;
                        end
                    end
                end
                RESP: begin
                    if (inst_ready)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en)
            pc_q <= pc;
        if (beat_clr)
            araddr_q <= {pc_q[31:4], 4'b0000};
        else if (chk_q && !finish)
            araddr_q <= araddr_q + 32'd4;   // Next single-beat word.
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(access_fault));

endmodule

// ==== hw/refill_buffer.sv ====
`timescale 1ns/100ps

module refill_buffer
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  clr,
    input  logic  take,
    input  beat_t beat,
    input  word_t rdata,
    input  resp_t rresp,
    output line_t line,
    output logic  err
);

    logic [LINE_WORDS-1:0] mask_q;   // Words filled in this refill.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err    <= 1'b0;
            mask_q <= '0;
        end else if (clr) begin
            err    <= 1'b0;
            mask_q <= '0;
        end else if (take) begin
            err          <= err || (rresp != RESP_OKAY);
            mask_q[beat] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            line[beat*WORD_BITS +: WORD_BITS] <= rdata;
    end

    a_no_refill_twice: assert property (@(posedge clk) disable iff (rst)
        take && !clr |-> !mask_q[beat]);

endmodule

// ==== hw/icache_array.sv ====
`timescale 1ns/100ps

module icache_array
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   lookup_en,
    input  index_t lookup_idx,
    input  tag_t   lookup_tag,
    input  beat_t  word_sel,
    input  logic   line_we,
    input  index_t line_idx,
    input  tag_t   line_tag,
    input  line_t  line,
    output logic   hit,
    output word_t  rd_word
);

    tag_t                 tag_mem [NUM_LINES];
    line_t                data_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    beat_t                sel_q;        // Word of the pending request.
    line_t                lookup_line;

    assign lookup_line = data_mem[lookup_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            hit     <= 1'b0;
        end else begin
            if (line_we)
                valid_q[line_idx] <= 1'b1;
            if (lookup_en)
                hit <= valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_mem[line_idx]  <= line_tag;
            data_mem[line_idx] <= line;
            // Refill also returns the requested word.
            rd_word <= line[sel_q*WORD_BITS +: WORD_BITS];
        end
        if (lookup_en) begin
            sel_q   <= word_sel;
            rd_word <= lookup_line[word_sel*WORD_BITS +: WORD_BITS];
        end
    end

endmodule

// ==== hw/beat_counter.sv ====
`timescale 1ns/100ps

module beat_counter
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  clr,
    input  logic  inc,
    output beat_t beat,
    output logic  beat_last
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat <= '0;
        end else if (clr) begin
            beat <= '0;
        end else if (inc) begin
            beat <= beat + 1'b1;    // Wraps after the last word.
        end
    end

    assign beat_last = (beat == beat_t'(LINE_WORDS - 1));

    a_clr_inc: assert property (@(posedge clk) disable iff (rst)
        !(clr && inc));

endmodule

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    localparam int WORD_BITS  = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_BITS  = LINE_WORDS * WORD_BITS;
    localparam int NUM_LINES  = 16;

    typedef logic [31:0]          addr_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;   // Word 0 in the low bits.
    typedef logic [3:0]           index_t;  // Address bits 7:4.
    typedef logic [23:0]          tag_t;    // Address bits 31:8.
    typedef logic [1:0]           beat_t;
    typedef logic [1:0]           resp_t;

    localparam addr_t SDRAM_BASE = 32'hA000_0000;
    localparam addr_t SDRAM_END  = 32'hBFFF_FFFF;

    localparam logic [3:0] FETCH_ID  = 4'h1;
    localparam resp_t      RESP_OKAY = 2'b00;

    localparam logic [2:0] AR_SIZE_WORD  = 3'd2;     // 4 bytes per beat.
    localparam logic [7:0] AR_LEN_LINE   = 8'(LINE_WORDS - 1);
    localparam logic [7:0] AR_LEN_SINGLE = 8'd0;
    localparam logic [1:0] BURST_FIXED   = 2'b00;
    localparam logic [1:0] BURST_INCR    = 2'b01;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ADDR,
        DATA,
        RESP
    } ctrl_state_t;

endpackage
